//--- common/predec_pkg.sv
package predec_pkg;

  // Opcode map selected by the escape bytes in front of the opcode
  typedef enum logic [1:0] {
    MAP_1B   = 2'd0,
    MAP_0F   = 2'd1,
    MAP_0F38 = 2'd2,
    MAP_0F3A = 2'd3
  } map_t;

  // Rep class of the last legacy prefix seen before the opcode
  typedef enum logic [1:0] {
    REP_NONE = 2'd0,
    REP_66   = 2'd1,
    REP_F2   = 2'd2,  // Shared with the 67 address size prefix
    REP_F3   = 2'd3   // Shared with lock
  } rep_t;

  // Table index is {map, opcode}, split into a word address and a bit offset
  localparam int TBL_INDEX_W = 10;
  localparam int TBL_WORD_W  = 64;
  localparam int TBL_ADDR_W  = 4;

  localparam logic [7:0] PFX_OPSIZE = 8'h66;
  localparam logic [7:0] PFX_ADSIZE = 8'h67;
  localparam logic [7:0] PFX_REPNE  = 8'hF2;
  localparam logic [7:0] PFX_REP    = 8'hF3;
  localparam logic [7:0] PFX_LOCK   = 8'hF0;
  localparam logic [3:0] PFX_REX_HI = 4'h4;  // REX is 0x40 to 0x4F in 64-bit mode

  localparam logic [7:0] ESC_0F = 8'h0F;
  localparam logic [7:0] ESC_38 = 8'h38;
  localparam logic [7:0] ESC_3A = 8'h3A;

  // ModRM addressing forms
  localparam logic [2:0] MODRM_RM_SIB  = 3'b100;
  localparam logic [2:0] MODRM_RM_DISP = 3'b101;
  localparam logic [1:0] MODRM_MOD_REG = 2'b11;
  localparam logic [1:0] MODRM_MOD_IND = 2'b00;

endpackage

//--- prefix/first_set.sv
`timescale 1ns/1ns

module first_set #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] req,
  output logic [WIDTH-1:0] grant,
  output logic             found
);

  logic [WIDTH-1:0] lower_hit;

  // lower_hit[i] is set when some request below bit i is already set
  always_comb begin
    lower_hit[0] = 1'b0;
    for (int i = 1; i < WIDTH; i++) begin
      lower_hit[i] = lower_hit[i-1] | req[i-1];
    end
  end

  assign grant = req & ~lower_hit;
  assign found = |req;

endmodule

//--- prefix/prefix_scan.sv
`timescale 1ns/1ns

module prefix_scan
  import predec_pkg::*;
#(
  parameter int WINDOW_BYTES = 10
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  logic [8*WINDOW_BYTES-1:0] window,
  input  logic                      mode64,
  output logic [TBL_INDEX_W-1:0]    rd_index,
  output logic                      scan_valid,
  output logic [8*WINDOW_BYTES-1:0] window_q,
  output logic [7:0]                opcode,
  output map_t                      map,
  output rep_t                      rep,
  output logic [3:0]                rex,
  output logic                      rex3_valid,
  output logic [3:0]                rex3,
  output logic                      no_opcode,
  output logic [WINDOW_BYTES-3:0]   opcode_pos
);

  localparam int SCAN = WINDOW_BYTES - 2;  // Leaves room for ModRM and SIB

  logic [SCAN-1:0] is_rep;
  logic [SCAN-1:0] is_rex;
  logic [SCAN-1:0] is_rex3;
  logic [SCAN-1:0] is_esc;
  logic [SCAN-1:0] not_pfx;
  rep_t            pos_rep [SCAN];
  map_t            pos_map [SCAN];

  logic [SCAN-1:0] opc_grant;
  logic            opc_found;
  logic [7:0]      m_opcode;
  map_t            m_map;
  rep_t            m_rep;
  logic [3:0]      m_rex;
  logic            m_rex3_valid;
  logic [3:0]      m_rex3;

  // Per-byte classification, with the escape level carried from earlier bytes
  always_comb begin
    logic [7:0] b;
    logic [7:0] prev;
    logic       lvl;
    prev = 8'h00;
    lvl  = 1'b0;
    for (int p = 0; p < SCAN; p++) begin
      b          = window[8*p +: 8];
      pos_rep[p] = REP_NONE;
      pos_map[p] = MAP_1B;
      is_esc[p]  = 1'b0;
      is_rex[p]  = 1'b0;
      is_rex3[p] = 1'b0;
      if (!lvl) begin
        if (b == PFX_OPSIZE)
          pos_rep[p] = REP_66;
        else if (b == PFX_REPNE || b == PFX_ADSIZE)
          pos_rep[p] = REP_F2;
        else if (b == PFX_REP || b == PFX_LOCK)
          pos_rep[p] = REP_F3;
        // A REX right after another REX carries the third register operand
        is_rex[p]  = mode64 && b[7:4] == PFX_REX_HI && prev[7:4] != PFX_REX_HI;
        is_rex3[p] = mode64 && b[7:4] == PFX_REX_HI && prev[7:4] == PFX_REX_HI;
        if (b == ESC_0F) begin
          is_esc[p]  = 1'b1;
          pos_map[p] = MAP_0F;
        end
      end else if (prev == ESC_0F && (b == ESC_38 || b == ESC_3A)) begin
        is_esc[p]  = 1'b1;
        pos_map[p] = (b == ESC_38) ? MAP_0F38 : MAP_0F3A;
      end
      is_rep[p]  = pos_rep[p] != REP_NONE;
      not_pfx[p] = !(is_rep[p] || is_rex[p] || is_rex3[p] || is_esc[p]);
      lvl        = lvl | (b == ESC_0F);
      prev       = b;
    end
  end

  first_set #(
    .WIDTH(SCAN)
  ) first_set_inst (
    .req  (not_pfx),
    .grant(opc_grant),
    .found(opc_found)
  );

  // Prefix fields up to the opcode, the last one of each kind wins
  always_comb begin
    logic in_run;
    in_run       = 1'b1;
    m_opcode     = 8'h00;
    m_map        = MAP_1B;
    m_rep        = REP_NONE;
    m_rex        = 4'h0;
    m_rex3_valid = 1'b0;
    m_rex3       = 4'h0;
    for (int p = 0; p < SCAN; p++) begin
      if (opc_grant[p]) begin
        in_run   = 1'b0;
        m_opcode = window[8*p +: 8];
      end
      if (in_run) begin
        if (is_rep[p])
          m_rep = pos_rep[p];
        if (is_rex[p])
          m_rex = window[8*p +: 4];
        if (is_rex3[p]) begin
          m_rex3_valid = 1'b1;
          m_rex3       = window[8*p +: 4];
        end
        if (is_esc[p])
          m_map = pos_map[p];
      end
    end
    // A window of nothing but prefixes decodes to all zero fields
    if (!opc_found) begin
      m_map        = MAP_1B;
      m_rep        = REP_NONE;
      m_rex        = 4'h0;
      m_rex3_valid = 1'b0;
      m_rex3       = 4'h0;
    end
  end

  assign rd_index = {m_map, m_opcode};

  always_ff @(posedge clk) begin
    if (rst)
      scan_valid <= 1'b0;
    else
      scan_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    window_q   <= window;
    opcode     <= m_opcode;
    map        <= m_map;
    rep        <= m_rep;
    rex        <= m_rex;
    rex3_valid <= m_rex3_valid;
    rex3       <= m_rex3;
    no_opcode  <= !opc_found;
    opcode_pos <= opc_grant;
  end

  a_opcode_pos: assert property (@(posedge clk) disable iff (rst)
    scan_valid |-> $onehot0(opcode_pos) && (no_opcode == !(|opcode_pos)));

endmodule

//--- src/subreg_table.sv
`timescale 1ns/1ns

module subreg_table
  import predec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tbl_we,
  input  logic [TBL_ADDR_W-1:0]  tbl_addr,
  input  logic [TBL_WORD_W-1:0]  tbl_data,
  input  logic [TBL_INDEX_W-1:0] rd_index,
  output logic                   rd_bit
);

  localparam int TBL_BITS = TBL_WORD_W << TBL_ADDR_W;

  // The write words must tile the whole index space exactly
  if (TBL_BITS != (1 << TBL_INDEX_W)) begin : g_geometry_check
    $error("subreg_table word geometry does not cover the index space");
  end

  logic [TBL_BITS-1:0] bitmap;  // One bit per {map, opcode}

  always_ff @(posedge clk) begin
    if (rst) begin
      bitmap <= '0;
      rd_bit <= 1'b0;
    end else begin
      if (tbl_we) begin
        bitmap[TBL_WORD_W*tbl_addr +: TBL_WORD_W] <= tbl_data;
      end
      rd_bit <= bitmap[rd_index];  // Sees the old word when written on the same edge
    end
  end

  a_tbl_addr_known: assert property (@(posedge clk) disable iff (rst)
    tbl_we |-> !$isunknown(tbl_addr));

endmodule

//--- src/insn_combine.sv
`timescale 1ns/1ns

module insn_combine
  import predec_pkg::*;
#(
  parameter int WINDOW_BYTES = 10
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [8*WINDOW_BYTES-1:0] window_d,
  input  logic                      scan_valid,
  input  logic [7:0]                opcode,
  input  map_t                      map,
  input  rep_t                      rep,
  input  logic [3:0]                rex,
  input  logic                      rex3_valid,
  input  logic [3:0]                rex3,
  input  logic                      no_opcode,
  input  logic [WINDOW_BYTES-3:0]   opcode_pos,
  input  logic                      rd_bit,
  output logic                      out_valid,
  output logic [7:0]                out_opcode,
  output map_t                      out_map,
  output rep_t                      out_rep,
  output logic [3:0]                out_rex,
  output logic                      out_rex3_valid,
  output logic [3:0]                out_rex3,
  output logic                      out_no_opcode,
  output logic [7:0]                modrm,
  output logic [7:0]                sib,
  output logic                      has_sib,
  output logic                      disp32,
  output logic                      subreg,
  output logic [2:0]                sub_reg
);

  localparam int SCAN = WINDOW_BYTES - 2;

  logic [7:0] modrm_c;
  logic [7:0] sib_c;
  logic       has_sib_c;
  logic       disp32_c;
  logic       subreg_c;
  logic [2:0] sub_reg_c;

  // ModRM and SIB sit one and two bytes past the opcode
  always_comb begin
    modrm_c = 8'h00;
    sib_c   = 8'h00;
    for (int p = 0; p < SCAN; p++) begin
      if (opcode_pos[p]) begin
        modrm_c = modrm_c | window_d[8*(p+1) +: 8];
        sib_c   = sib_c | window_d[8*(p+2) +: 8];
      end
    end
  end

  assign has_sib_c = modrm_c[2:0] == MODRM_RM_SIB && modrm_c[7:6] != MODRM_MOD_REG;
  assign disp32_c  = modrm_c[7:6] == MODRM_MOD_IND && modrm_c[2:0] == MODRM_RM_DISP;

  // Index zero is still looked up when there is no opcode, so mask it here
  assign subreg_c  = rd_bit && !no_opcode;
  assign sub_reg_c = subreg_c ? modrm_c[5:3] : 3'b000;

  always_ff @(posedge clk) begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= scan_valid;
  end

  always_ff @(posedge clk) begin
    out_opcode     <= opcode;
    out_map        <= map;
    out_rep        <= rep;
    out_rex        <= rex;
    out_rex3_valid <= rex3_valid;
    out_rex3       <= rex3;
    out_no_opcode  <= no_opcode;
    modrm          <= modrm_c;
    sib            <= sib_c;
    has_sib        <= has_sib_c;
    disp32         <= disp32_c;
    subreg         <= subreg_c;
    sub_reg        <= sub_reg_c;
  end

  a_subreg_opcode: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !(subreg && out_no_opcode));

endmodule

//--- src/insn_predecode.sv
`timescale 1ns/1ns

module insn_predecode
  import predec_pkg::*;
#(
  parameter int WINDOW_BYTES = 10
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  logic [8*WINDOW_BYTES-1:0] window,
  input  logic                      mode64,
  input  logic                      tbl_we,
  input  logic [TBL_ADDR_W-1:0]     tbl_addr,
  input  logic [TBL_WORD_W-1:0]     tbl_data,
  output logic                      out_valid,
  output logic [7:0]                out_opcode,
  output map_t                      out_map,
  output rep_t                      out_rep,
  output logic [3:0]                out_rex,
  output logic                      out_rex3_valid,
  output logic [3:0]                out_rex3,
  output logic                      out_no_opcode,
  output logic [7:0]                modrm,
  output logic [7:0]                sib,
  output logic                      has_sib,
  output logic                      disp32,
  output logic                      subreg,
  output logic [2:0]                sub_reg
);

  logic [TBL_INDEX_W-1:0]    rd_index;
  logic                      rd_bit;
  logic                      scan_valid;
  logic [8*WINDOW_BYTES-1:0] window_q;
  logic [7:0]                opcode;
  map_t                      map;
  rep_t                      rep;
  logic [3:0]                rex;
  logic                      rex3_valid;
  logic [3:0]                rex3;
  logic                      no_opcode;
  logic [WINDOW_BYTES-3:0]   opcode_pos;

  // The table lookup runs in the same cycle as the scan register
  prefix_scan #(
    .WINDOW_BYTES(WINDOW_BYTES)
  ) prefix_scan_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .window    (window),
    .mode64    (mode64),
    .rd_index  (rd_index),
    .scan_valid(scan_valid),
    .window_q  (window_q),
    .opcode    (opcode),
    .map       (map),
    .rep       (rep),
    .rex       (rex),
    .rex3_valid(rex3_valid),
    .rex3      (rex3),
    .no_opcode (no_opcode),
    .opcode_pos(opcode_pos)
  );

  subreg_table subreg_table_inst (
    .clk     (clk),
    .rst     (rst),
    .tbl_we  (tbl_we),
    .tbl_addr(tbl_addr),
    .tbl_data(tbl_data),
    .rd_index(rd_index),
    .rd_bit  (rd_bit)
  );

  insn_combine #(
    .WINDOW_BYTES(WINDOW_BYTES)
  ) insn_combine_inst (
    .clk           (clk),
    .rst           (rst),
    .window_d      (window_q),
    .scan_valid    (scan_valid),
    .opcode        (opcode),
    .map           (map),
    .rep           (rep),
    .rex           (rex),
    .rex3_valid    (rex3_valid),
    .rex3          (rex3),
    .no_opcode     (no_opcode),
    .opcode_pos    (opcode_pos),
    .rd_bit        (rd_bit),
    .out_valid     (out_valid),
    .out_opcode    (out_opcode),
    .out_map       (out_map),
    .out_rep       (out_rep),
    .out_rex       (out_rex),
    .out_rex3_valid(out_rex3_valid),
    .out_rex3      (out_rex3),
    .out_no_opcode (out_no_opcode),
    .modrm         (modrm),
    .sib           (sib),
    .has_sib       (has_sib),
    .disp32        (disp32),
    .subreg        (subreg),
    .sub_reg       (sub_reg)
  );

endmodule

//--- test/predec_model.svh
`ifndef PREDEC_MODEL_SVH
`define PREDEC_MODEL_SVH

// Expected decode of one window, in the order the DUT presents its fields
typedef struct packed {
  logic [7:0] opcode;
  logic [1:0] map;
  logic [1:0] rep;
  logic [3:0] rex;
  logic       rex3_valid;
  logic [3:0] rex3;
  logic       no_opcode;
  logic [7:0] modrm;
  logic [7:0] sib;
  logic       has_sib;
  logic       disp32;
  logic       subreg;
  logic [2:0] sub_reg;
} exp_t;

logic [1023:0] shadow_tbl;  // Mirrors the subregister bitmap

function automatic exp_t model_decode(input logic [8*WINDOW_BYTES-1:0] w, input logic m64);
  exp_t       e;
  logic [7:0] b;
  logic       found;
  logic       prev_rex;
  int         esc_pos;
  int         pos;
  e        = '0;
  found    = 1'b0;
  prev_rex = 1'b0;
  esc_pos  = -1;
  pos      = 0;
  for (int p = 0; p < WINDOW_BYTES - 2 && !found; p++) begin
    b = w[8*p +: 8];
    if (e.map != 2'd0) begin
      // After an escape only 38 or 3A directly behind 0F is still an escape
      if (e.map == 2'd1 && p == esc_pos + 1 && (b == 8'h38 || b == 8'h3A)) begin
        e.map = (b == 8'h38) ? 2'd2 : 2'd3;
      end else begin
        found = 1'b1;
        pos   = p;
      end
    end else if (b == 8'h66) begin
      e.rep = 2'd1;
    end else if (b == 8'hF2 || b == 8'h67) begin
      e.rep = 2'd2;
    end else if (b == 8'hF3 || b == 8'hF0) begin
      e.rep = 2'd3;
    end else if (m64 && b[7:4] == 4'h4) begin
      if (prev_rex) begin
        e.rex3_valid = 1'b1;
        e.rex3       = b[3:0];
      end else begin
        e.rex = b[3:0];
      end
    end else if (b == 8'h0F) begin
      e.map   = 2'd1;
      esc_pos = p;
    end else begin
      found = 1'b1;
      pos   = p;
    end
    prev_rex = m64 && b[7:4] == 4'h4;
  end
  if (!found) begin
    e           = '0;
    e.no_opcode = 1'b1;
    return e;
  end
  e.opcode  = w[8*pos +: 8];
  e.modrm   = w[8*(pos+1) +: 8];
  e.sib     = w[8*(pos+2) +: 8];
  e.has_sib = e.modrm[2:0] == 3'b100 && e.modrm[7:6] != 2'b11;
  e.disp32  = e.modrm[7:6] == 2'b00 && e.modrm[2:0] == 3'b101;
  e.subreg  = shadow_tbl[{e.map, e.opcode}];
  e.sub_reg = e.subreg ? e.modrm[5:3] : 3'b000;
  return e;
endfunction

`endif

//--- test/tb_insn_predecode.sv
`timescale 1ns/1ns

module tb_insn_predecode
  import predec_pkg::*;
();

  localparam int WINDOW_BYTES = 10;
  localparam int N_PREFIX = 300;
  localparam int N_ONLY_PFX = 100;
  localparam int N_MODRM = 200;
  localparam int N_SUBREG = 400;
  localparam int N_STREAM = 200;
  localparam int TOTAL_CYCLES = N_PREFIX + N_ONLY_PFX + N_MODRM + N_SUBREG + N_STREAM + 100;

  logic                      clk;
  logic                      rst;
  logic                      in_valid;
  logic [8*WINDOW_BYTES-1:0] window;
  logic                      mode64;
  logic                      tbl_we;
  logic [TBL_ADDR_W-1:0]     tbl_addr;
  logic [TBL_WORD_W-1:0]     tbl_data;
  logic                      out_valid;
  logic [7:0]                out_opcode;
  map_t                      out_map;
  rep_t                      out_rep;
  logic [3:0]                out_rex;
  logic                      out_rex3_valid;
  logic [3:0]                out_rex3;
  logic                      out_no_opcode;
  logic [7:0]                modrm;
  logic [7:0]                sib;
  logic                      has_sib;
  logic                      disp32;
  logic                      subreg;
  logic [2:0]                sub_reg;

  integer seed = 32;
  int     errors = 0;
  int     cyc = 0;
  int     tests_run = 0;

  `include "predec_model.svh"

  exp_t exp_q[$];
  int   due_q[$];

  insn_predecode #(
    .WINDOW_BYTES(WINDOW_BYTES)
  ) insn_predecode_inst (
    .clk(clk), .rst(rst), .in_valid(in_valid), .window(window), .mode64(mode64),
    .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
    .out_valid(out_valid), .out_opcode(out_opcode), .out_map(out_map), .out_rep(out_rep),
    .out_rex(out_rex), .out_rex3_valid(out_rex3_valid), .out_rex3(out_rex3),
    .out_no_opcode(out_no_opcode), .modrm(modrm), .sib(sib), .has_sib(has_sib),
    .disp32(disp32), .subreg(subreg), .sub_reg(sub_reg)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Watchdog sized from the vector counts plus reset and drain margin
  initial begin
    #(TOTAL_CYCLES * 40);
    $display("Timeout: the run did not complete within %0d cycles", TOTAL_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // Prefixes, REX and escapes are drawn far more often than plain bytes
  function automatic logic [7:0] pool_byte();
    int r;
    r = $random(seed) & 15;
    case (r)
      0: return 8'h66;
      1: return 8'h67;
      2: return 8'hF2;
      3: return 8'hF3;
      4: return 8'hF0;
      5, 6: return {4'h4, 4'($random(seed))};
      7, 8: return 8'h0F;
      9: return 8'h38;
      10: return 8'h3A;
      default: return 8'($random(seed));
    endcase
  endfunction

  // A byte that is always a prefix in the given mode
  function automatic logic [7:0] prefix_only_byte(input int r, input logic m64);
    case (r)
      0: return 8'h66;
      1: return 8'h67;
      2: return 8'hF2;
      3: return 8'hF3;
      4: return 8'hF0;
      default: return m64 ? {4'h4, 4'($random(seed))} : 8'h66;
    endcase
  endfunction

  function automatic logic [8*WINDOW_BYTES-1:0] make_window(input logic only_pfx,
                                                            input logic m64);
    logic [8*WINDOW_BYTES-1:0] w;
    int r;
    for (int i = 0; i < WINDOW_BYTES; i++) begin
      r = $random(seed) % 6;
      if (r < 0)
        r = -r;
      if (only_pfx && i < WINDOW_BYTES - 2)
        w[8*i +: 8] = prefix_only_byte(r, m64);
      else
        w[8*i +: 8] = pool_byte();
    end
    return w;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got %0h expected %0h at cycle %0d", name, got, exp, cyc);
      errors++;
    end
  endtask

  task automatic check_outputs();
    exp_t e;
    int   due;
    if (rst) begin
      assert (out_valid === 1'b0) else begin
        $display("out_valid was high during reset at cycle %0d", cyc);
        errors++;
      end
    end else if (out_valid) begin
      assert (exp_q.size() > 0) else begin
        $display("out_valid was high with no window outstanding at cycle %0d", cyc);
        errors++;
      end
      if (exp_q.size() > 0) begin
        e   = exp_q.pop_front();
        due = due_q.pop_front();
        assert (due == cyc) else begin
          $display("Result arrived at cycle %0d instead of cycle %0d", cyc, due);
          errors++;
        end
        check_field("out_opcode", out_opcode, e.opcode);
        check_field("out_map", out_map, e.map);
        check_field("out_rep", out_rep, e.rep);
        check_field("out_rex", out_rex, e.rex);
        check_field("out_rex3_valid", out_rex3_valid, e.rex3_valid);
        check_field("out_rex3", out_rex3, e.rex3);
        check_field("out_no_opcode", out_no_opcode, e.no_opcode);
        check_field("modrm", modrm, e.modrm);
        check_field("sib", sib, e.sib);
        check_field("has_sib", has_sib, e.has_sib);
        check_field("disp32", disp32, e.disp32);
        check_field("subreg", subreg, e.subreg);
        check_field("sub_reg", sub_reg, e.sub_reg);
      end
    end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
      assert (0) else begin
        $display("out_valid missing for the result due at cycle %0d", due_q[0]);
        errors++;
      end
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end
  endtask

  // One falling edge: check what the DUT shows, then drive the next inputs
  task automatic drive_cycle(input logic v, input logic m64, input logic only_pfx,
                             input logic we);
    @(negedge clk);
    check_outputs();
    in_valid = v;
    mode64   = m64;
    window   = make_window(only_pfx, m64);
    tbl_we   = we;
    tbl_addr = 4'($random(seed));
    tbl_data = {32'($random(seed)), 32'($random(seed))};
    if (v) begin
      exp_q.push_back(model_decode(window, m64));  // Same-edge write is not yet visible
      due_q.push_back(cyc + 2);
    end
    if (we)
      shadow_tbl[TBL_WORD_W*tbl_addr +: TBL_WORD_W] = tbl_data;
  endtask

  task automatic drain();
    for (int i = 0; i < 8; i++)
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic report_test(input string name, input int vectors, input int err_before);
    tests_run++;
    $display("Test %0d %s: %0d vectors, %0d errors", tests_run, name, vectors,
             errors - err_before);
  endtask

  initial begin
    int e0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    window     = '0;
    mode64     = 1'b0;
    tbl_we     = 1'b0;
    tbl_addr   = '0;
    tbl_data   = '0;
    shadow_tbl = '0;
    repeat (8) begin
      @(negedge clk);
      check_outputs();
    end
    rst = 1'b0;

    e0 = errors;
    for (int i = 0; i < N_PREFIX; i++)
      drive_cycle(1'($random(seed)), 1'($random(seed)), 1'b0, 1'b0);
    drain();
    report_test("prefix decode", N_PREFIX, e0);

    e0 = errors;
    for (int i = 0; i < N_ONLY_PFX; i++)
      drive_cycle(1'b1, 1'($random(seed)), i % 2 == 0, 1'b0);
    drain();
    report_test("opcode location and no_opcode", N_ONLY_PFX, e0);

    e0 = errors;
    for (int i = 0; i < N_MODRM; i++)
      drive_cycle(1'b1, 1'b1, 1'b0, 1'b0);
    drain();
    report_test("ModRM and SIB fields", N_MODRM, e0);

    e0 = errors;
    for (int i = 0; i < N_SUBREG; i++)
      drive_cycle(1'($random(seed)) | (i % 3 == 0), 1'($random(seed)), 1'b0,
                  1'($random(seed)));
    drain();
    report_test("subregister lookup", N_SUBREG, e0);

    e0 = errors;
    for (int i = 0; i < N_STREAM; i++)
      drive_cycle(1'b1, 1'($random(seed)), 1'b0, 1'($random(seed)));
    drain();
    assert (exp_q.size() == 0) else begin
      $display("%0d results never came out", exp_q.size());
      errors++;
    end
    report_test("back-to-back streaming", N_STREAM, e0);

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+test
common/predec_pkg.sv
prefix/first_set.sv
prefix/prefix_scan.sv
src/subreg_table.sv
src/insn_combine.sv
src/insn_predecode.sv
test/tb_insn_predecode.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_insn_predecode
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
